// ==== src/exec_pkg.sv ====
/* execution cluster shared definitions
   unit codes, per-unit op encodings and the issue function word */
package exec_pkg;

  localparam int TAG_W   = 4;
  localparam int N_UNITS = 4;

  // unit code doubles as the arbiter requester index
  typedef enum logic [1:0] {
    FU_ALU,
    FU_BR,
    FU_MUL,
    FU_DIV
  } fu_code_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_fn_t;

  typedef enum logic [3:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE,
    BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_fn_t;

  typedef enum logic [3:0] {
    MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
  } mul_fn_t;

  typedef enum logic [3:0] {
    DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU
  } div_fn_t;

  // one function word, read through the member of the target unit
  typedef union packed {
    alu_fn_t alu;
    br_fn_t  br;
    mul_fn_t mul;
    div_fn_t div;
  } uop_fn_u;

endpackage

// ==== src/alu_unit.sv ====
`timescale 1ns/1ps
/* integer ALU
   ten register-register ops captured into a one-entry result slot */
module alu_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  exec_pkg::alu_fn_t          fn,
  input  logic [exec_pkg::TAG_W-1:0] tag,
  input  logic [31:0]                in1,
  input  logic [31:0]                in2,
  output logic                       req,
  input  logic                       grant,
  output logic [31:0]                res_data,
  output logic [exec_pkg::TAG_W-1:0] res_tag,
  output logic                       ready
);
  import exec_pkg::*;

  logic        full;
  logic [4:0]  shamt;
  logic [31:0] result;

  assign shamt = in2[4:0];

  always_comb begin
    case (fn)
      ALU_ADD:  result = in1 + in2;
      ALU_SUB:  result = in1 - in2;
      ALU_SLT:  result = {31'd0, $signed(in1) < $signed(in2)};
      ALU_SLTU: result = {31'd0, in1 < in2};
      ALU_XOR:  result = in1 ^ in2;
      ALU_OR:   result = in1 | in2;
      ALU_AND:  result = in1 & in2;
      ALU_SLL:  result = in1 << shamt;
      ALU_SRL:  result = in1 >> shamt;
      ALU_SRA:  result = $signed(in1) >>> shamt;
      default:  result = '0;
    endcase
  end

  assign req   = full;
  assign ready = !full || grant;  // slot frees on the grant edge

  always_ff @(posedge clock) begin
    if (reset)
      full <= 1'b0;
    else if (start)
      full <= 1'b1;
    else if (grant)
      full <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (start) begin
      res_data <= result;
      res_tag  <= tag;
    end
  end

  assert property (@(posedge clock) disable iff (reset) start |-> ready)
    else $error("alu issue while slot busy");

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps
/* branch unit
   evaluates the condition, computes target and link into a result slot */
module branch_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  exec_pkg::br_fn_t           fn,
  input  logic [exec_pkg::TAG_W-1:0] tag,
  input  logic [31:0]                in1,
  input  logic [31:0]                in2,
  input  logic [31:0]                pc,
  input  logic [31:0]                imm,
  output logic                       req,
  input  logic                       grant,
  output logic [31:0]                res_data,
  output logic [exec_pkg::TAG_W-1:0] res_tag,
  output logic                       res_taken,
  output logic [31:0]                res_target,
  output logic                       ready
);
  import exec_pkg::*;

  logic        full;
  logic        cond;
  logic        is_jump;
  logic [31:0] pc_next;
  logic [31:0] target;

  always_comb begin
    case (fn)
      BR_EQ:   cond = (in1 == in2);
      BR_NE:   cond = (in1 != in2);
      BR_LT:   cond = ($signed(in1) < $signed(in2));
      BR_GE:   cond = ($signed(in1) >= $signed(in2));
      BR_LTU:  cond = (in1 < in2);
      BR_GEU:  cond = (in1 >= in2);
      BR_JAL,
      BR_JALR: cond = 1'b1;  // jumps always taken
      default: cond = 1'b0;
    endcase
  end

  assign is_jump = (fn == BR_JAL) || (fn == BR_JALR);
  assign pc_next = pc + 32'd4;

  always_comb begin
    if (fn == BR_JALR)
      target = (in1 + imm) & ~32'd1;
    else if (cond)
      target = pc + imm;
    else
      target = pc_next;
  end

  assign req   = full;
  assign ready = !full || grant;

  always_ff @(posedge clock) begin
    if (reset)
      full <= 1'b0;
    else if (start)
      full <= 1'b1;
    else if (grant)
      full <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (start) begin
      res_data   <= is_jump ? pc_next : 32'd0;  // link value
      res_tag    <= tag;
      res_taken  <= cond;
      res_target <= target;
    end
  end

endmodule

// ==== src/mul_unit.sv ====
`timescale 1ns/1ps
/* pipelined multiplier
   33-bit extended operands, product carried down MUL_STAGES stages,
   whole pipe freezes while the last stage waits for its grant */
module mul_unit #(
  parameter int MUL_STAGES = 3
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  exec_pkg::mul_fn_t          fn,
  input  logic [exec_pkg::TAG_W-1:0] tag,
  input  logic [31:0]                in1,
  input  logic [31:0]                in2,
  output logic                       req,
  input  logic                       grant,
  output logic [31:0]                res_data,
  output logic [exec_pkg::TAG_W-1:0] res_tag,
  output logic                       ready
);
  import exec_pkg::*;

  logic               a_signed;
  logic               b_signed;
  logic signed [32:0] a_ext;
  logic signed [32:0] b_ext;
  logic signed [65:0] product;
  logic               advance;

  logic [MUL_STAGES-1:0] stg_valid;
  logic [MUL_STAGES-1:0] stg_hi;  // high word select
  logic [TAG_W-1:0]      stg_tag  [MUL_STAGES];
  logic [65:0]           stg_prod [MUL_STAGES];

  assign a_signed = (fn != MUL_MULHU);
  assign b_signed = (fn == MUL_MUL) || (fn == MUL_MULH);
  assign a_ext    = {a_signed & in1[31], in1};
  assign b_ext    = {b_signed & in2[31], in2};
  assign product  = a_ext * b_ext;

  assign advance = !stg_valid[MUL_STAGES-1] || grant;
  assign ready   = advance;

  always_ff @(posedge clock) begin
    if (reset)
      stg_valid <= '0;
    else if (advance)
      stg_valid <= {stg_valid[MUL_STAGES-2:0], start};
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      stg_hi      <= {stg_hi[MUL_STAGES-2:0], fn != MUL_MUL};
      stg_tag[0]  <= tag;
      stg_prod[0] <= product;
      for (int i = 1; i < MUL_STAGES; i++) begin
        stg_tag[i]  <= stg_tag[i-1];
        stg_prod[i] <= stg_prod[i-1];
      end
    end
  end

  assign req      = stg_valid[MUL_STAGES-1];
  assign res_tag  = stg_tag[MUL_STAGES-1];
  assign res_data = stg_hi[MUL_STAGES-1] ? stg_prod[MUL_STAGES-1][63:32]
                                         : stg_prod[MUL_STAGES-1][31:0];

  // an issue into a frozen pipe would be lost
  assert property (@(posedge clock) disable iff (reset) start |-> advance)
    else $error("mul issue while pipe frozen");

endmodule

// ==== src/div_unit.sv ====
`timescale 1ns/1ps
/* iterative divider
   32 restoring shift-subtract steps on magnitudes, then sign fix-up,
   one division in flight at a time */
module div_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  exec_pkg::div_fn_t          fn,
  input  logic [exec_pkg::TAG_W-1:0] tag,
  input  logic [31:0]                in1,
  input  logic [31:0]                in2,
  output logic                       req,
  input  logic                       grant,
  output logic [31:0]                res_data,
  output logic [exec_pkg::TAG_W-1:0] res_tag,
  output logic                       ready
);
  import exec_pkg::*;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_DONE = 2'd2;

  logic [1:0]  state;
  logic [4:0]  count;
  logic [31:0] dvsr;
  logic [31:0] quo;  // dividend shifts out as quotient shifts in
  logic [31:0] rem;
  logic        neg_q;
  logic        neg_r;
  logic        want_rem;
  logic        op_signed;
  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [32:0] rem_sh;
  logic [33:0] diff;

  assign op_signed = (fn == DIV_DIV) || (fn == DIV_REM);
  assign a_neg     = op_signed && in1[31];
  assign b_neg     = op_signed && in2[31];
  assign a_mag     = a_neg ? -in1 : in1;
  assign b_mag     = b_neg ? -in2 : in2;

  assign rem_sh = {rem, quo[31]};
  assign diff   = {1'b0, rem_sh} - {2'b00, dvsr};

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (start) state <= S_RUN;
        S_RUN:   if (count == 5'd0) state <= S_DONE;
        S_DONE:  if (grant) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      quo      <= a_mag;
      rem      <= '0;
      dvsr     <= b_mag;
      count    <= 5'd31;
      // x/0 must stay all ones, overflow needs no fix since -1 flips nothing
      neg_q    <= (a_neg ^ b_neg) && (in2 != 32'd0);
      neg_r    <= a_neg;
      want_rem <= (fn == DIV_REM) || (fn == DIV_REMU);
      res_tag  <= tag;
    end else if (state == S_RUN) begin
      count <= count - 5'd1;
      if (!diff[33]) begin
        rem <= diff[31:0];
        quo <= {quo[30:0], 1'b1};
      end else begin
        rem <= rem_sh[31:0];  // restore
        quo <= {quo[30:0], 1'b0};
      end
    end
  end

  assign res_data = want_rem ? (neg_r ? -rem : rem) : (neg_q ? -quo : quo);
  assign req      = (state == S_DONE);
  assign ready    = (state == S_IDLE);

  assert property (@(posedge clock) disable iff (reset) start |-> ready)
    else $error("div issue while busy");

endmodule

// ==== src/wb_arbiter.sv ====
`timescale 1ns/1ps
/* writeback arbiter
   round-robin grant among the units, gated by a credit counter,
   winner registered onto the writeback bus */
module wb_arbiter #(
  parameter int WB_CREDITS = 2
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [exec_pkg::N_UNITS-1:0] req,
  output logic [exec_pkg::N_UNITS-1:0] grant,
  input  logic [31:0]                  in_data_alu,
  input  logic [31:0]                  in_data_br,
  input  logic [31:0]                  in_data_mul,
  input  logic [31:0]                  in_data_div,
  input  logic [exec_pkg::TAG_W-1:0]   in_tag_alu,
  input  logic [exec_pkg::TAG_W-1:0]   in_tag_br,
  input  logic [exec_pkg::TAG_W-1:0]   in_tag_mul,
  input  logic [exec_pkg::TAG_W-1:0]   in_tag_div,
  input  logic                         in_taken_alu,
  input  logic                         in_taken_br,
  input  logic                         in_taken_mul,
  input  logic                         in_taken_div,
  input  logic [31:0]                  in_target_alu,
  input  logic [31:0]                  in_target_br,
  input  logic [31:0]                  in_target_mul,
  input  logic [31:0]                  in_target_div,
  input  logic                         wb_credit,
  output logic                         wb_valid,
  output exec_pkg::fu_code_t           wb_unit,
  output logic [exec_pkg::TAG_W-1:0]   wb_tag,
  output logic [31:0]                  wb_data,
  output logic                         wb_taken,
  output logic [31:0]                  wb_target
);
  import exec_pkg::*;

  localparam int CW = $clog2(WB_CREDITS + 2);  // room to see an overflow
  localparam int UW = $clog2(N_UNITS);

  logic [31:0]        data_in   [N_UNITS];
  logic [TAG_W-1:0]   tag_in    [N_UNITS];
  logic [31:0]        target_in [N_UNITS];
  logic [N_UNITS-1:0] taken_in;
  logic [CW-1:0]      credits;
  logic [UW-1:0]      last;
  logic [UW-1:0]      winner;
  logic               found;
  logic               fire;

  assign data_in[FU_ALU]   = in_data_alu;
  assign data_in[FU_BR]    = in_data_br;
  assign data_in[FU_MUL]   = in_data_mul;
  assign data_in[FU_DIV]   = in_data_div;
  assign tag_in[FU_ALU]    = in_tag_alu;
  assign tag_in[FU_BR]     = in_tag_br;
  assign tag_in[FU_MUL]    = in_tag_mul;
  assign tag_in[FU_DIV]    = in_tag_div;
  assign target_in[FU_ALU] = in_target_alu;
  assign target_in[FU_BR]  = in_target_br;
  assign target_in[FU_MUL] = in_target_mul;
  assign target_in[FU_DIV] = in_target_div;
  assign taken_in          = {in_taken_div, in_taken_mul, in_taken_br, in_taken_alu};

  // search starts just after the last winner
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = last;
    for (int i = 1; i <= N_UNITS; i++) begin
      idx = (int'(last) + i) % N_UNITS;
      if (!found && req[idx]) begin
        found  = 1'b1;
        winner = UW'(idx);
      end
    end
  end

  assign fire  = found && (credits != '0);
  assign grant = fire ? (N_UNITS'(1) << winner) : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
      last     <= UW'(N_UNITS - 1);  // alu first after reset
      credits  <= CW'(WB_CREDITS);
    end else begin
      wb_valid <= fire;
      if (fire)
        last <= winner;
      credits <= credits + CW'(wb_credit) - CW'(fire);
    end
  end

  always_ff @(posedge clock) begin
    if (fire) begin
      wb_unit   <= fu_code_t'(winner);
      wb_tag    <= tag_in[winner];
      wb_data   <= data_in[winner];
      wb_taken  <= taken_in[winner];
      wb_target <= target_in[winner];
    end
  end

  // consumer never hands back more than it was sent
  assert property (@(posedge clock) disable iff (reset) credits <= CW'(WB_CREDITS))
    else $error("writeback credit overflow");

endmodule

// ==== src/exec_cluster.sv ====
`timescale 1ns/1ps
/* execution cluster top
   routes each issue to one of four units and merges results on one bus */
module exec_cluster #(
  parameter int MUL_STAGES = 3,
  parameter int WB_CREDITS = 2
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         issue_valid,
  input  exec_pkg::fu_code_t           issue_unit,
  input  exec_pkg::uop_fn_u            issue_fn,
  input  logic [exec_pkg::TAG_W-1:0]   issue_tag,
  input  logic [31:0]                  issue_in1,
  input  logic [31:0]                  issue_in2,
  input  logic [31:0]                  issue_pc,
  input  logic [31:0]                  issue_imm,
  output logic [exec_pkg::N_UNITS-1:0] unit_ready,
  output logic                         wb_valid,
  output exec_pkg::fu_code_t           wb_unit,
  output logic [exec_pkg::TAG_W-1:0]   wb_tag,
  output logic [31:0]                  wb_data,
  output logic                         wb_taken,
  output logic [31:0]                  wb_target,
  input  logic                         wb_credit
);
  import exec_pkg::*;

  logic [N_UNITS-1:0] start;
  logic [N_UNITS-1:0] req;
  logic [N_UNITS-1:0] grant;
  logic [31:0]        alu_data, br_data, mul_data, div_data;
  logic [TAG_W-1:0]   alu_tag, br_tag, mul_tag, div_tag;
  logic               br_taken;
  logic [31:0]        br_target;

  assign start[FU_ALU] = issue_valid && (issue_unit == FU_ALU);
  assign start[FU_BR]  = issue_valid && (issue_unit == FU_BR);
  assign start[FU_MUL] = issue_valid && (issue_unit == FU_MUL);
  assign start[FU_DIV] = issue_valid && (issue_unit == FU_DIV);

  alu_unit u_alu (
    .clock(clock), .reset(reset), .start(start[FU_ALU]), .fn(issue_fn.alu),
    .tag(issue_tag), .in1(issue_in1), .in2(issue_in2),
    .req(req[FU_ALU]), .grant(grant[FU_ALU]),
    .res_data(alu_data), .res_tag(alu_tag), .ready(unit_ready[FU_ALU])
  );

  branch_unit u_br (
    .clock(clock), .reset(reset), .start(start[FU_BR]), .fn(issue_fn.br),
    .tag(issue_tag), .in1(issue_in1), .in2(issue_in2),
    .pc(issue_pc), .imm(issue_imm),
    .req(req[FU_BR]), .grant(grant[FU_BR]),
    .res_data(br_data), .res_tag(br_tag), .res_taken(br_taken),
    .res_target(br_target), .ready(unit_ready[FU_BR])
  );

  mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul (
    .clock(clock), .reset(reset), .start(start[FU_MUL]), .fn(issue_fn.mul),
    .tag(issue_tag), .in1(issue_in1), .in2(issue_in2),
    .req(req[FU_MUL]), .grant(grant[FU_MUL]),
    .res_data(mul_data), .res_tag(mul_tag), .ready(unit_ready[FU_MUL])
  );

  div_unit u_div (
    .clock(clock), .reset(reset), .start(start[FU_DIV]), .fn(issue_fn.div),
    .tag(issue_tag), .in1(issue_in1), .in2(issue_in2),
    .req(req[FU_DIV]), .grant(grant[FU_DIV]),
    .res_data(div_data), .res_tag(div_tag), .ready(unit_ready[FU_DIV])
  );

  // only the branch unit produces taken and target
  wb_arbiter #(.WB_CREDITS(WB_CREDITS)) u_arb (
    .clock(clock), .reset(reset), .req(req), .grant(grant),
    .in_data_alu(alu_data), .in_data_br(br_data),
    .in_data_mul(mul_data), .in_data_div(div_data),
    .in_tag_alu(alu_tag), .in_tag_br(br_tag),
    .in_tag_mul(mul_tag), .in_tag_div(div_tag),
    .in_taken_alu(1'b0), .in_taken_br(br_taken),
    .in_taken_mul(1'b0), .in_taken_div(1'b0),
    .in_target_alu(32'd0), .in_target_br(br_target),
    .in_target_mul(32'd0), .in_target_div(32'd0),
    .wb_credit(wb_credit), .wb_valid(wb_valid), .wb_unit(wb_unit),
    .wb_tag(wb_tag), .wb_data(wb_data), .wb_taken(wb_taken), .wb_target(wb_target)
  );

endmodule

// ==== verif/exec_cluster_tb.sv ====
`timescale 1ns/1ps
/* execution cluster testbench
   random issue to all four units, per-tag expected tables,
   credit return with a stall window, checks as concurrent assertions */
module exec_cluster_tb;
  import exec_pkg::*;

  localparam int WB_CREDITS = 2;
  localparam int TIMEOUT    = 2000;

  logic               clock = 1'b0;
  logic               reset = 1'b1;
  logic               issue_valid = 1'b0;
  fu_code_t           issue_unit = FU_ALU;
  uop_fn_u            issue_fn = '0;
  logic [TAG_W-1:0]   issue_tag = '0;
  logic [31:0]        issue_in1 = '0;
  logic [31:0]        issue_in2 = '0;
  logic [31:0]        issue_pc = '0;
  logic [31:0]        issue_imm = '0;
  logic [N_UNITS-1:0] unit_ready;
  logic               wb_valid;
  fu_code_t           wb_unit;
  logic [TAG_W-1:0]   wb_tag;
  logic [31:0]        wb_data;
  logic               wb_taken;
  logic [31:0]        wb_target;
  logic               wb_credit = 1'b0;

  // scoreboard, one entry per tag
  logic [31:0] exp_data   [16];
  logic [31:0] exp_target [16];
  logic        exp_taken  [16];
  fu_code_t    exp_unit   [16];
  logic [15:0] issued_flag = '0;
  logic [15:0] retired_flag = '0;
  wire  [15:0] pending = issued_flag ^ retired_flag;  // toggles differ while in flight

  integer      seed = 32'h46a6_ac24;
  int          tag_ptr = 0;
  int          issue_count = 0;
  int          retire_count = 0;
  int          out_cnt = 0;  // results sent minus credits returned
  int unsigned cycle_count = 0;
  int unsigned credit_due [$];
  logic        hold_credits = 1'b0;
  logic        any_issued = 1'b0;

  always #4 clock = ~clock;

  exec_cluster u_dut (
    .clock(clock), .reset(reset),
    .issue_valid(issue_valid), .issue_unit(issue_unit), .issue_fn(issue_fn),
    .issue_tag(issue_tag), .issue_in1(issue_in1), .issue_in2(issue_in2),
    .issue_pc(issue_pc), .issue_imm(issue_imm), .unit_ready(unit_ready),
    .wb_valid(wb_valid), .wb_unit(wb_unit), .wb_tag(wb_tag), .wb_data(wb_data),
    .wb_taken(wb_taken), .wb_target(wb_target), .wb_credit(wb_credit)
  );

  task automatic stop_with(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic [3:0] rand_fn(input fu_code_t unit);
    int unsigned r;
    r = $unsigned($random(seed));
    case (unit)
      FU_ALU:  rand_fn = 4'(r % 10);
      FU_BR:   rand_fn = 4'(r % 8);
      default: rand_fn = 4'(r % 4);
    endcase
  endfunction

  function automatic int free_tag();
    int t;
    free_tag = -1;
    for (int i = 0; i < 16; i++) begin
      t = (tag_ptr + i) % 16;
      if (free_tag < 0 && !pending[t])
        free_tag = t;
    end
  endfunction

  // operand corner cases, k picks the pair
  task automatic operand_pair(input int k, output logic [31:0] a, output logic [31:0] b);
    a = rand_word();
    b = rand_word();
    case (k)
      1: begin
        a = 32'h8000_0000;
        b = 32'h0000_001f;
      end
      2: begin
        a = 32'hffff_ffff;
        b = 32'h0000_0001;
      end
      3: begin
        a = 32'h7fff_ffff;
        b = 32'h8000_0000;
      end
      4: b = 32'd0;
      5: begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end
      6: b = a;
      default: ;
    endcase
  endtask

  function automatic logic [31:0] alu_model(input logic [3:0] fn, input logic [31:0] a,
                                            input logic [31:0] b);
    case (fn)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [3:0] fn, input logic [31:0] a,
                                        input logic [31:0] b);
    case (fn)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return $signed(a) < $signed(b);
      BR_GE:   return $signed(a) >= $signed(b);
      BR_LTU:  return a < b;
      BR_GEU:  return a >= b;
      BR_JAL,
      BR_JALR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] branch_target(input logic [3:0] fn, input logic [31:0] a,
                                                input logic [31:0] b, input logic [31:0] pc,
                                                input logic [31:0] imm);
    if (fn == BR_JALR)
      return (a + imm) & 32'hffff_fffe;
    if (branch_taken(fn, a, b))
      return pc + imm;
    return pc + 32'd4;
  endfunction

  function automatic logic [31:0] mul_model(input logic [3:0] fn, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [63:0] p;
    case (fn)
      MUL_MULH:   p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      MUL_MULHSU: p = $signed({{32{a[31]}}, a}) * $signed({32'd0, b});
      MUL_MULHU:  p = {32'd0, a} * {32'd0, b};
      default:    p = {32'd0, a} * {32'd0, b};
    endcase
    return (fn == MUL_MUL) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic [31:0] div_model(input logic [3:0] fn, input logic [31:0] a,
                                            input logic [31:0] b);
    logic        is_signed;
    logic [31:0] q;
    logic [31:0] r;
    is_signed = (fn == DIV_DIV) || (fn == DIV_REM);
    if (b == 32'd0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;  // overflow case
      r = 32'd0;
    end else if (is_signed) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return (fn == DIV_REM || fn == DIV_REMU) ? r : q;
  endfunction

  // caller has checked ready and a free tag in this cycle
  task automatic issue_now(input fu_code_t unit, input logic [3:0] fn, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] pc, input logic [31:0] imm);
    int t;
    t = free_tag();
    tag_ptr = (t + 1) % 16;
    exp_unit[t]   = unit;
    exp_taken[t]  = 1'b0;
    exp_target[t] = 32'd0;
    case (unit)
      FU_ALU: exp_data[t] = alu_model(fn, a, b);
      FU_BR: begin
        exp_data[t]   = (fn == BR_JAL || fn == BR_JALR) ? pc + 32'd4 : 32'd0;
        exp_taken[t]  = branch_taken(fn, a, b);
        exp_target[t] = branch_target(fn, a, b, pc, imm);
      end
      FU_MUL: exp_data[t] = mul_model(fn, a, b);
      default: exp_data[t] = div_model(fn, a, b);
    endcase
    issued_flag[t] = ~issued_flag[t];
    any_issued  = 1'b1;
    issue_valid = 1'b1;
    issue_unit  = unit;
    issue_fn    = fn;
    issue_tag   = t[TAG_W-1:0];
    issue_in1   = a;
    issue_in2   = b;
    issue_pc    = pc;
    issue_imm   = imm;
    issue_count++;
    next_cycle();
    issue_valid = 1'b0;
  endtask

  task automatic issue_op(input fu_code_t unit, input logic [3:0] fn, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] pc, input logic [31:0] imm);
    int waited;
    waited = 0;
    while (!(unit_ready[unit] && free_tag() >= 0)) begin
      if (waited >= TIMEOUT) begin
        stop_with("timeout waiting for results");
      end else begin
        next_cycle();
        waited++;
      end
    end
    issue_now(unit, fn, a, b, pc, imm);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending != 16'd0) begin
      if (waited >= TIMEOUT) begin
        stop_with("timeout waiting for results");
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  // consumer side, one credit back per result after a short random delay
  always @(posedge clock) begin : credit_return
    logic hold_now;
    hold_now = hold_credits;
    cycle_count = cycle_count + 1;
    out_cnt = out_cnt + ((wb_valid === 1'b1) ? 1 : 0) - ((wb_credit === 1'b1) ? 1 : 0);
    if (wb_valid === 1'b1)
      credit_due.push_back(cycle_count + ($unsigned($random(seed)) % 4));
    #1;
    wb_credit = 1'b0;
    if (!hold_now && credit_due.size() > 0 && credit_due[0] <= cycle_count) begin
      wb_credit = 1'b1;
      void'(credit_due.pop_front());
    end
  end

  always @(posedge clock) begin
    if (!reset && wb_valid === 1'b1) begin
      retired_flag[wb_tag] = ~retired_flag[wb_tag];
      retire_count = retire_count + 1;
    end
  end

  // checks sampled mid-cycle where outputs are settled
  a_reset_idle: assert property (@(negedge clock) disable iff (reset)
    !any_issued |-> !wb_valid && unit_ready == {N_UNITS{1'b1}})
    else stop_with("outputs not idle after reset");

  // one division at a time, ready drops as soon as one starts
  a_div_busy: assert property (@(negedge clock) disable iff (reset)
    issue_valid && issue_unit == FU_DIV |=> !unit_ready[FU_DIV])
    else stop_with("divider still ready after a division was issued");

  a_known_tag: assert property (@(negedge clock) disable iff (reset)
    wb_valid |-> pending[wb_tag])
    else stop_with($sformatf("result for tag %h that is not in flight", wb_tag));

  a_unit: assert property (@(negedge clock) disable iff (reset)
    wb_valid |-> wb_unit == exp_unit[wb_tag])
    else stop_with($sformatf("Mismatch wb_unit tag=%h got=%h exp=%h",
                             wb_tag, wb_unit, exp_unit[wb_tag]));

  a_data: assert property (@(negedge clock) disable iff (reset)
    wb_valid |-> wb_data == exp_data[wb_tag])
    else stop_with($sformatf("Mismatch wb_data tag=%h got=%h exp=%h",
                             wb_tag, wb_data, exp_data[wb_tag]));

  a_taken: assert property (@(negedge clock) disable iff (reset)
    wb_valid |-> wb_taken == exp_taken[wb_tag])
    else stop_with($sformatf("Mismatch wb_taken tag=%h got=%h exp=%h",
                             wb_tag, wb_taken, exp_taken[wb_tag]));

  a_target: assert property (@(negedge clock) disable iff (reset)
    wb_valid |-> wb_target == exp_target[wb_tag])
    else stop_with($sformatf("Mismatch wb_target tag=%h got=%h exp=%h",
                             wb_tag, wb_target, exp_target[wb_tag]));

  a_credit_bound: assert property (@(negedge clock) disable iff (reset)
    out_cnt <= WB_CREDITS)
    else stop_with("more results sent than credits allow");

  a_hold: assert property (@(negedge clock) disable iff (reset)
    hold_credits && !wb_credit && out_cnt == WB_CREDITS |-> !wb_valid)
    else stop_with("result sent while all credits were withheld");

  initial begin
    fu_code_t    u;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] imm;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (4) next_cycle();

    for (int f = 0; f < 10; f++) begin
      for (int k = 0; k < 6; k++) begin
        operand_pair(k, a, b);
        issue_op(FU_ALU, 4'(f), a, b, 32'd0, 32'd0);
      end
    end

    for (int f = 0; f < 8; f++) begin
      for (int k = 0; k < 7; k++) begin
        operand_pair(k, a, b);
        pc  = rand_word() & 32'hffff_fffc;
        imm = (rand_word() & 32'h0000_0ffe) | {31'd0, ~a[0]};  // in1+imm odd for jalr
        issue_op(FU_BR, 4'(f), a, b, pc, imm);
      end
    end

    for (int k = 0; k < 6; k++) begin  // back to back, pipe fills
      for (int f = 0; f < 4; f++) begin
        operand_pair(k, a, b);
        issue_op(FU_MUL, 4'(f), a, b, 32'd0, 32'd0);
      end
    end

    for (int k = 0; k < 6; k++) begin
      for (int f = 0; f < 4; f++) begin
        operand_pair(k, a, b);
        issue_op(FU_DIV, 4'(f), a, b, 32'd0, 32'd0);
      end
    end
    drain();

    // stall window, slots fill and ready drops
    hold_credits = 1'b1;
    for (int i = 0; i < 40; i++) begin
      u = fu_code_t'(i % 3);
      if (unit_ready[u] && free_tag() >= 0)
        issue_now(u, rand_fn(u), rand_word(), rand_word(), rand_word() & 32'hffff_fffc,
                  rand_word() & 32'h0000_0ffe);
      else
        next_cycle();
    end
    hold_credits = 1'b0;

    for (int i = 0; i < 60; i++) begin
      u = fu_code_t'($unsigned($random(seed)) % 4);
      issue_op(u, rand_fn(u), rand_word(), rand_word(), rand_word() & 32'hffff_fffc,
               rand_word() & 32'h0000_0ffe);
    end
    drain();
    repeat (4) next_cycle();

    if (pending != 16'd0 || retire_count != issue_count) begin
      stop_with($sformatf("issued %0d results but %0d retired", issue_count, retire_count));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// ==== exec_cluster.f ====
src/exec_pkg.sv
src/alu_unit.sv
src/branch_unit.sv
src/mul_unit.sv
src/div_unit.sv
src/wb_arbiter.sv
src/exec_cluster.sv
verif/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f exec_cluster.f \
  --top-module exec_cluster_tb -o exec_cluster_sim
./obj_dir/exec_cluster_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST OK" sim.log
